// File: logic/user_out_pkg.sv
// Shared constants for the user output stage
//   Default stream and burst widths
//   Default command queue depth
//   Bit position of the source select in a command word

package user_out_pkg;

  // ------------------------------------------------------------------
  // Stream defaults
  // ------------------------------------------------------------------
  localparam int DEF_DATA_BITS = 64;
  localparam int DEF_TID_BITS  = 6;

  // ------------------------------------------------------------------
  // Command defaults
  // ------------------------------------------------------------------
  // Count field holds beats minus one
  localparam int DEF_BLEN_BITS = 6;
  localparam int DEF_CMD_DEPTH = 4;

  // Source select just above the count picks the response source when 1
  localparam int CMD_RESP_POS  = DEF_BLEN_BITS;

endpackage

// File: logic/axis_intf.sv
// Stream interface for links inside the output stage
//   Data, byte keep, last, id and valid/ready handshake
//   Modport m for the sender, modport s for the receiver

`timescale 1ns/10ps

interface axis_intf import user_out_pkg::*; #(
  parameter int DATA_BITS = DEF_DATA_BITS,
  parameter int TID_BITS  = DEF_TID_BITS
);

  // One keep bit per data byte
  localparam int KEEP_BITS = DATA_BITS / 8;

  logic [DATA_BITS-1:0] tdata;
  logic [KEEP_BITS-1:0] tkeep;
  logic                 tlast;
  logic [TID_BITS-1:0]  tid;
  logic                 tvalid;
  logic                 tready;

  // Sender side
  modport m (output tdata, tkeep, tlast, tid, tvalid, input tready);

  // Receiver side
  modport s (input tdata, tkeep, tlast, tid, tvalid, output tready);

endinterface

// File: logic/mux_cmd_queue.sv
// Merge command queue
//   Circular buffer with read/write pointers and occupancy count
//   Valid/ready handshake on write and read side
//   Write and read in the same cycle are both accepted

`timescale 1ns/10ps

module mux_cmd_queue import user_out_pkg::*; #(
  parameter int CMD_DEPTH = DEF_CMD_DEPTH,
  parameter int BLEN_BITS = DEF_BLEN_BITS
) (
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic [BLEN_BITS:0] in_data,
  output logic               out_valid,
  input  logic               out_ready,
  output logic [BLEN_BITS:0] out_data
);

  localparam int PTR_BITS = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(CMD_DEPTH + 1);

  // Command storage
  logic [BLEN_BITS:0] mem [CMD_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                wr_fire;
  logic                rd_fire;

  // Full only when every slot holds a command
  assign in_ready  = (count != CNT_BITS'(CMD_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign wr_fire = in_valid & in_ready;
  assign rd_fire = out_valid & out_ready;

  // ------------------------------------------------------------------
  // Storage write
  // ------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap after the last slot
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous write and read leave the count unchanged
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (!wr_fire && rd_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: logic/axis_mux_user_out.sv
// Command-driven two-to-one burst merger
//   Idle/merge FSM with beat counter and registered source select
//   Combinational steering of the selected source to the output
//   Next command taken on the last beat, so bursts run back to back

`timescale 1ns/10ps

module axis_mux_user_out import user_out_pkg::*; #(
  parameter int BLEN_BITS = DEF_BLEN_BITS
) (
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  logic [BLEN_BITS:0] cmd_data,
  axis_intf.s                s_axis_resp,
  axis_intf.s                s_axis_recv,
  axis_intf.m                m_axis
);

  // FSM encoding
  localparam logic ST_IDLE  = 1'b0;
  localparam logic ST_MERGE = 1'b1;

  logic                 state;
  logic [BLEN_BITS-1:0] cnt;
  logic                 sel_resp;

  logic out_fire;
  logic last_beat;
  logic take_cmd;

  // ------------------------------------------------------------------
  // Data path steering
  // ------------------------------------------------------------------
  always_comb begin
    if (state == ST_MERGE) begin
      m_axis.tdata  = sel_resp ? s_axis_resp.tdata  : s_axis_recv.tdata;
      m_axis.tkeep  = sel_resp ? s_axis_resp.tkeep  : s_axis_recv.tkeep;
      m_axis.tlast  = sel_resp ? s_axis_resp.tlast  : s_axis_recv.tlast;
      m_axis.tid    = sel_resp ? s_axis_resp.tid    : s_axis_recv.tid;
      m_axis.tvalid = sel_resp ? s_axis_resp.tvalid : s_axis_recv.tvalid;
      // Only the selected source sees ready
      s_axis_resp.tready = sel_resp & m_axis.tready;
      s_axis_recv.tready = !sel_resp & m_axis.tready;
    end else begin
      // Idle holds both sources
      m_axis.tdata       = '0;
      m_axis.tkeep       = '0;
      m_axis.tlast       = 1'b0;
      m_axis.tid         = '0;
      m_axis.tvalid      = 1'b0;
      s_axis_resp.tready = 1'b0;
      s_axis_recv.tready = 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // Command acceptance
  // ------------------------------------------------------------------
  assign out_fire  = m_axis.tvalid & m_axis.tready;
  // Count of zero means the current beat closes the burst
  assign last_beat = (state == ST_MERGE) && (cnt == '0) && out_fire;
  assign cmd_ready = (state == ST_IDLE) || last_beat;
  assign take_cmd  = cmd_valid & cmd_ready;

  // ------------------------------------------------------------------
  // State, counter and select
  // ------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      sel_resp <= 1'b0;
    end else begin
      if (take_cmd) begin
        // New burst from idle or straight after the last beat
        state    <= ST_MERGE;
        cnt      <= cmd_data[BLEN_BITS-1:0];
        sel_resp <= cmd_data[CMD_RESP_POS];
      end else if (last_beat) begin
        // Nothing queued
        state <= ST_IDLE;
      end else if (out_fire) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

// File: logic/axis_skid_buffer.sv
// Output register slice
//   Main register drives the output, skid register catches one beat
//   Registered input ready, full rate while the output is ready

`timescale 1ns/10ps

module axis_skid_buffer import user_out_pkg::*; #(
  parameter int DATA_BITS = DEF_DATA_BITS,
  parameter int TID_BITS  = DEF_TID_BITS
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  axis_intf.s                    s_axis,
  output logic [DATA_BITS-1:0]   out_tdata,
  output logic [DATA_BITS/8-1:0] out_tkeep,
  output logic                   out_tlast,
  output logic [TID_BITS-1:0]    out_tid,
  output logic                   out_tvalid,
  input  logic                   out_tready
);

  localparam int KEEP_BITS = DATA_BITS / 8;

  // Skid register and handshake state
  logic [DATA_BITS-1:0] skid_tdata;
  logic [KEEP_BITS-1:0] skid_tkeep;
  logic                 skid_tlast;
  logic [TID_BITS-1:0]  skid_tid;
  logic                 skid_valid;
  logic                 rdy;
  logic                 in_fire;
  logic                 main_free;

  assign s_axis.tready = rdy;
  assign in_fire       = s_axis.tvalid & rdy;
  // Main register empties or hands its beat over this cycle
  assign main_free     = !out_tvalid || out_tready;

  // ------------------------------------------------------------------
  // Valid flags and ready
  // ------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_tvalid <= 1'b0;
      skid_valid <= 1'b0;
      rdy        <= 1'b0;
    end else if (main_free) begin
      // Skid beat goes first while the input is held off
      out_tvalid <= skid_valid || in_fire;
      skid_valid <= 1'b0;
      rdy        <= 1'b1;
    end else if (in_fire) begin
      // Park the beat and drop ready while main is stalled
      skid_valid <= 1'b1;
      rdy        <= 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // Payload registers
  // ------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (main_free) begin
      out_tdata <= skid_valid ? skid_tdata : s_axis.tdata;
      out_tkeep <= skid_valid ? skid_tkeep : s_axis.tkeep;
      out_tlast <= skid_valid ? skid_tlast : s_axis.tlast;
      out_tid   <= skid_valid ? skid_tid   : s_axis.tid;
    end else if (in_fire) begin
      skid_tdata <= s_axis.tdata;
      skid_tkeep <= s_axis.tkeep;
      skid_tlast <= s_axis.tlast;
      skid_tid   <= s_axis.tid;
    end
  end

endmodule

// File: logic/user_out_top.sv
// User output stage top level
//   Plain ports mapped onto stream interfaces
//   Command queue, burst merger and output skid buffer in a chain

`timescale 1ns/10ps

module user_out_top import user_out_pkg::*; #(
  parameter int DATA_BITS = DEF_DATA_BITS,
  parameter int TID_BITS  = DEF_TID_BITS,
  parameter int BLEN_BITS = DEF_BLEN_BITS,
  parameter int CMD_DEPTH = DEF_CMD_DEPTH
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  // Merge commands
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  logic [BLEN_BITS:0]     cmd_data,
  // Response source
  input  logic [DATA_BITS-1:0]   resp_tdata,
  input  logic [DATA_BITS/8-1:0] resp_tkeep,
  input  logic                   resp_tlast,
  input  logic [TID_BITS-1:0]    resp_tid,
  input  logic                   resp_tvalid,
  output logic                   resp_tready,
  // Receive source
  input  logic [DATA_BITS-1:0]   recv_tdata,
  input  logic [DATA_BITS/8-1:0] recv_tkeep,
  input  logic                   recv_tlast,
  input  logic [TID_BITS-1:0]    recv_tid,
  input  logic                   recv_tvalid,
  output logic                   recv_tready,
  // Merged output
  output logic [DATA_BITS-1:0]   out_tdata,
  output logic [DATA_BITS/8-1:0] out_tkeep,
  output logic                   out_tlast,
  output logic [TID_BITS-1:0]    out_tid,
  output logic                   out_tvalid,
  input  logic                   out_tready
);

  // Queue to merger command link
  logic               q_valid;
  logic               q_ready;
  logic [BLEN_BITS:0] q_data;

  axis_intf #(.DATA_BITS(DATA_BITS), .TID_BITS(TID_BITS)) resp_if ();
  axis_intf #(.DATA_BITS(DATA_BITS), .TID_BITS(TID_BITS)) recv_if ();
  axis_intf #(.DATA_BITS(DATA_BITS), .TID_BITS(TID_BITS)) mrg_if ();

  // ------------------------------------------------------------------
  // Port to interface mapping
  // ------------------------------------------------------------------
  assign resp_if.tdata  = resp_tdata;
  assign resp_if.tkeep  = resp_tkeep;
  assign resp_if.tlast  = resp_tlast;
  assign resp_if.tid    = resp_tid;
  assign resp_if.tvalid = resp_tvalid;
  assign resp_tready    = resp_if.tready;

  assign recv_if.tdata  = recv_tdata;
  assign recv_if.tkeep  = recv_tkeep;
  assign recv_if.tlast  = recv_tlast;
  assign recv_if.tid    = recv_tid;
  assign recv_if.tvalid = recv_tvalid;
  assign recv_tready    = recv_if.tready;

  // ------------------------------------------------------------------
  // Processing chain
  // ------------------------------------------------------------------
  mux_cmd_queue #(.CMD_DEPTH(CMD_DEPTH), .BLEN_BITS(BLEN_BITS)) cmd_q0 (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_data   (cmd_data),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_data)
  );

  axis_mux_user_out #(.BLEN_BITS(BLEN_BITS)) mux0 (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_valid   (q_valid),
    .cmd_ready   (q_ready),
    .cmd_data    (q_data),
    .s_axis_resp (resp_if.s),
    .s_axis_recv (recv_if.s),
    .m_axis      (mrg_if.m)
  );

  // Registered boundary towards the user port
  axis_skid_buffer #(.DATA_BITS(DATA_BITS), .TID_BITS(TID_BITS)) skid0 (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_axis     (mrg_if.s),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tlast  (out_tlast),
    .out_tid    (out_tid),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready)
  );

endmodule

// File: bench/user_out_props.sv
// Bound assertions for the burst merger
//   Source readys never high together
//   Output valid and payload held while stalled
//   No output valid in the idle state

`timescale 1ns/10ps

module user_out_props import user_out_pkg::*; #(
  parameter int PAY_BITS = DEF_DATA_BITS + DEF_DATA_BITS / 8 + 1 + DEF_TID_BITS
) (
  input logic                aclk,
  input logic                aresetn,
  input logic                state,
  input logic                resp_tready,
  input logic                recv_tready,
  input logic                m_tvalid,
  input logic                m_tready,
  input logic [PAY_BITS-1:0] m_payload
);

  // Number of failed properties so far
  int unsigned fail_count = 0;

  // Only the selected source may see ready
  ready_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
    !(resp_tready && recv_tready))
  else begin
    fail_count++;
    $error("both source treadys high in the same cycle");
  end

  // Stalled beat must not change
  stall_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_payload)))
  else begin
    fail_count++;
    $error("merged output changed while stalled");
  end

  // Idle state is encoded as 0
  idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    (state == 1'b0) |-> !m_tvalid)
  else begin
    fail_count++;
    $error("merged output valid while idle");
  end

endmodule

bind axis_mux_user_out user_out_props props0 (
  .aclk        (aclk),
  .aresetn     (aresetn),
  .state       (state),
  .resp_tready (s_axis_resp.tready),
  .recv_tready (s_axis_recv.tready),
  .m_tvalid    (m_axis.tvalid),
  .m_tready    (m_axis.tready),
  .m_payload   ({m_axis.tdata, m_axis.tkeep, m_axis.tlast, m_axis.tid})
);

// File: bench/tb_user_out.sv
// Testbench for the user output stage
//   Loads commands, source beats and expected beats from a data file
//   One driver process per source plus one for the command port
//   Random output back-pressure, in-order check of every output beat

`timescale 1ns/10ps

module tb_user_out import user_out_pkg::*; ();

  localparam int KEEP_BITS  = DEF_DATA_BITS / 8;
  localparam int BEAT_BITS  = DEF_DATA_BITS + KEEP_BITS + 1 + DEF_TID_BITS;
  localparam int WAIT_LIMIT = 2000;

  logic                     aclk;
  logic                     aresetn;
  logic                     cmd_valid;
  logic                     cmd_ready;
  logic [DEF_BLEN_BITS:0]   cmd_data;
  logic [DEF_DATA_BITS-1:0] resp_tdata;
  logic [KEEP_BITS-1:0]     resp_tkeep;
  logic                     resp_tlast;
  logic [DEF_TID_BITS-1:0]  resp_tid;
  logic                     resp_tvalid;
  logic                     resp_tready;
  logic [DEF_DATA_BITS-1:0] recv_tdata;
  logic [KEEP_BITS-1:0]     recv_tkeep;
  logic                     recv_tlast;
  logic [DEF_TID_BITS-1:0]  recv_tid;
  logic                     recv_tvalid;
  logic                     recv_tready;
  logic [DEF_DATA_BITS-1:0] out_tdata;
  logic [KEEP_BITS-1:0]     out_tkeep;
  logic                     out_tlast;
  logic [DEF_TID_BITS-1:0]  out_tid;
  logic                     out_tvalid;
  logic                     out_tready;

  // Stimulus and expected beats packed as {data, keep, last, id}
  logic [DEF_BLEN_BITS:0] cmd_q [$];
  logic [BEAT_BITS-1:0]   resp_q [$];
  logic [BEAT_BITS-1:0]   recv_q [$];
  logic [BEAT_BITS-1:0]   exp_q [$];

  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int exp_idx = 0;
  int beats_from_cmds = 0;
  bit resp_done = 1'b0;
  bit recv_done = 1'b0;
  bit cmd_done = 1'b0;
  bit cmd_full_seen = 1'b0;

  user_out_top dut0 (.*);

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic check_value(input string field, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, field, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic load_testdata();
    int                       fd;
    int                       code;
    int                       src;
    int                       cnt;
    logic [63:0]              tag;
    logic [8*200-1:0]         rest;
    logic [DEF_BLEN_BITS:0]   word;
    logic [DEF_DATA_BITS-1:0] d;
    logic [KEEP_BITS-1:0]     k;
    logic                     l;
    logic [DEF_TID_BITS-1:0]  id;
    fd = $fopen("bench/user_out_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test data file");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "C") begin
        code = $fscanf(fd, "%d %d", src, cnt);
        // Count in the low field with the source select just above it
        word = '0;
        word[DEF_BLEN_BITS-1:0] = cnt[DEF_BLEN_BITS-1:0];
        word[CMD_RESP_POS] = src[0];
        cmd_q.push_back(word);
        beats_from_cmds += cnt + 1;
      end else begin
        code = $fscanf(fd, "%h %h %h %h", d, k, l, id);
        if (tag == "P") resp_q.push_back({d, k, l, id});
        else if (tag == "R") recv_q.push_back({d, k, l, id});
        else exp_q.push_back({d, k, l, id});
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_reset_release(input string who);
    int n;
    n = 0;
    while (aresetn !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge aclk);
      n++;
    end
    if (n >= WAIT_LIMIT) note_timeout({who, " never saw reset released"});
    #0.5;
  endtask

  // Present one beat and hold it until the source handshake
  task automatic send_beat(input bit to_resp, input logic [BEAT_BITS-1:0] beat);
    int   n;
    logic rdy;
    if (to_resp) begin
      {resp_tdata, resp_tkeep, resp_tlast, resp_tid} = beat;
      resp_tvalid = 1'b1;
    end else begin
      {recv_tdata, recv_tkeep, recv_tlast, recv_tid} = beat;
      recv_tvalid = 1'b1;
    end
    n = 0;
    rdy = 1'b0;
    while (!rdy && n < WAIT_LIMIT) begin
      @(negedge aclk);
      rdy = to_resp ? resp_tready : recv_tready;
      n++;
    end
    if (!rdy) note_timeout(to_resp ? "response beat not taken" : "receive beat not taken");
    @(posedge aclk);
    #0.5;
  endtask

  // ------------------------------------------------------------------
  // Clock and back-pressure
  // ------------------------------------------------------------------
  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  initial begin
    void'($urandom(32'h375c_1ce3));
    forever begin
      @(posedge aclk);
      #0.5;
      // Ready low about 30% of cycles
      out_tready = ($urandom % 100) >= 30;
    end
  end

  // ------------------------------------------------------------------
  // Source and command drivers
  // ------------------------------------------------------------------
  initial begin
    wait_reset_release("response driver");
    foreach (resp_q[i]) send_beat(1'b1, resp_q[i]);
    resp_tvalid = 1'b0;
    resp_done = 1'b1;
  end

  initial begin
    wait_reset_release("receive driver");
    foreach (recv_q[i]) send_beat(1'b0, recv_q[i]);
    recv_tvalid = 1'b0;
    recv_done = 1'b1;
  end

  initial begin
    int n;
    bit acc;
    wait_reset_release("command driver");
    // Sources valid with no command yet so nothing may move
    repeat (20) begin
      @(negedge aclk);
      check_value("idle out_tvalid", out_tvalid, 0);
      check_value("idle resp_tready", resp_tready, 0);
      check_value("idle recv_tready", recv_tready, 0);
    end
    @(posedge aclk);
    #0.5;
    // Back to back, no gap between commands
    foreach (cmd_q[i]) begin
      cmd_valid = 1'b1;
      cmd_data = cmd_q[i];
      n = 0;
      acc = 1'b0;
      while (!acc && n < WAIT_LIMIT) begin
        @(negedge aclk);
        acc = cmd_ready;
        if (!cmd_ready) cmd_full_seen = 1'b1;
        n++;
      end
      if (!acc) note_timeout("command not accepted");
      @(posedge aclk);
      #0.5;
    end
    cmd_valid = 1'b0;
    cmd_done = 1'b1;
  end

  // ------------------------------------------------------------------
  // Output monitor
  // ------------------------------------------------------------------
  initial begin
    logic [DEF_DATA_BITS-1:0] e_data;
    logic [KEEP_BITS-1:0]     e_keep;
    logic                     e_last;
    logic [DEF_TID_BITS-1:0]  e_id;
    forever begin
      @(negedge aclk);
      if (aresetn === 1'b1 && out_tvalid && out_tready) begin
        if (exp_idx < exp_q.size()) begin
          {e_data, e_keep, e_last, e_id} = exp_q[exp_idx];
          check_value($sformatf("beat %0d tdata", exp_idx), out_tdata, e_data);
          check_value($sformatf("beat %0d tkeep", exp_idx), out_tkeep, e_keep);
          check_value($sformatf("beat %0d tlast", exp_idx), out_tlast, e_last);
          check_value($sformatf("beat %0d tid", exp_idx), out_tid, e_id);
        end else begin
          errors++;
          $display("Extra output beat at %0t, no expected beat left", $time);
        end
        exp_idx++;
      end
    end
  end

  // ------------------------------------------------------------------
  // Reset, completion and summary
  // ------------------------------------------------------------------
  initial begin
    int n;
    int asrt_fails;
    aresetn = 1'b0;
    cmd_valid = 1'b0;
    cmd_data = '0;
    {resp_tdata, resp_tkeep, resp_tlast, resp_tid, resp_tvalid} = '0;
    {recv_tdata, recv_tkeep, recv_tlast, recv_tid, recv_tvalid} = '0;
    out_tready = 1'b0;
    load_testdata();
    check_value("expected beat count", exp_q.size(), beats_from_cmds);
    repeat (16) @(posedge aclk);
    #0.5;
    aresetn = 1'b1;
    n = 0;
    while (!(resp_done && recv_done && cmd_done && exp_idx >= exp_q.size())
           && timeouts == 0 && n < 4 * WAIT_LIMIT) begin
      @(posedge aclk);
      n++;
    end
    if (n >= 4 * WAIT_LIMIT) note_timeout("output stream did not complete");
    // Drain window for stray beats
    repeat (20) @(posedge aclk);
    check_value("cmd_ready fell while full", cmd_full_seen, 1);
    check_value("output beat count", exp_idx, exp_q.size());
    asrt_fails = dut0.mux0.props0.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
             checks, errors, timeouts, asrt_fails);
    if (errors == 0 && timeouts == 0 && asrt_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: bench/user_out_testdata.txt
# C src count : src 1 = response, 0 = receive, count = beats minus one
# P/R/E data keep last id (hex) : response beat, receive beat, expected output beat
C 1 3
C 0 1
C 1 0
C 0 0
C 1 0
C 0 0
C 1 1
P a5a5000000001000 ff 0 05
P a5a5000000001001 ff 0 05
P a5a5000000001002 ff 0 05
P a5a5000000001003 0f 1 05
P a5a5000000001004 01 1 06
P a5a5000000001005 ff 1 07
P a5a5000000001006 ff 0 05
P a5a5000000001007 3f 1 05
R 3c3c00000000c000 ff 0 2a
R 3c3c00000000c001 07 1 2a
R 3c3c00000000c002 ff 1 2b
R 3c3c00000000c003 80 1 2c
E a5a5000000001000 ff 0 05
E a5a5000000001001 ff 0 05
E a5a5000000001002 ff 0 05
E a5a5000000001003 0f 1 05
E 3c3c00000000c000 ff 0 2a
E 3c3c00000000c001 07 1 2a
E a5a5000000001004 01 1 06
E 3c3c00000000c002 ff 1 2b
E a5a5000000001005 ff 1 07
E 3c3c00000000c003 80 1 2c
E a5a5000000001006 ff 0 05
E a5a5000000001007 3f 1 05

// File: files.f
logic/user_out_pkg.sv
logic/axis_intf.sv
logic/mux_cmd_queue.sv
logic/axis_mux_user_out.sv
logic/axis_skid_buffer.sv
logic/user_out_top.sv
bench/user_out_props.sv
bench/tb_user_out.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the user output stage testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_user_out -o sim_user_out
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_user_out +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
